// File: common/rv32i_defines.svh
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// datapath width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NUM_REGS 32

// addi x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

`endif

// File: common/rv32i_pkg.sv
`default_nettype none

`include "rv32i_defines.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv_word_t;                 // data, pc or instruction
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // base opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // branch conditions, same encoding as funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // second operand of the comparator
    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmp_src_t;

    typedef struct packed {
        opcode_t        opcode;
        alu_op_t        alu_op;
        branch_funct3_t cmpop;
        cmp_src_t       cmp_src;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        logic [3:0]     mem_byte_en;
        logic           illegal;
    } ctrl_word_t;

    // everything EX needs from decode
    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        rv_word_t   pc;
        rv_word_t   instr;
        rv_word_t   rs1_data;
        rv_word_t   rs2_data;
        rv_word_t   i_imm;
        rv_word_t   s_imm;
        rv_word_t   b_imm;
        rv_word_t   u_imm;
        rv_word_t   j_imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       br_en;
    } id_ex_t;

endpackage : rv32i_pkg

`default_nettype wire

// File: id_stage/control_rom.sv
`timescale 1ns/10ps
`default_nettype none

module control_rom
    import rv32i_pkg::*;
(
    input  opcode_t    opcode_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,
    output ctrl_word_t ctrl_o
);

    logic       alt;        // funct7 bit 5, sub/sra select
    logic       imm_form;
    logic [3:0] size_mask;
    ctrl_word_t ctrl;

    assign alt      = funct7_i[5];
    assign imm_form = (opcode_i == op_imm);

    // byte / half / word lanes from the size bits of funct3
    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.opcode  = opcode_i;
        ctrl.alu_op  = alu_add;
        ctrl.cmpop   = beq;
        ctrl.cmp_src = cmp_rs2;

        case (opcode_i)
            op_lui, op_auipc, op_jal, op_jalr: begin
                ctrl.load_regfile = 1'b1;   // alu adds pc/imm in EX
            end

            op_br: begin
                ctrl.cmpop   = branch_funct3_t'(funct3_i);
                ctrl.illegal = (funct3_i[2:1] == 2'b01); // 010 and 011 unused
            end

            op_load: begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_byte_en  = size_mask;
                // lb lh lw lbu lhu only
                ctrl.illegal      = (funct3_i[1:0] == 2'b11) || (funct3_i == 3'b110);
            end

            op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.mem_byte_en = size_mask;
                ctrl.illegal     = funct3_i[2] || (funct3_i[1:0] == 2'b11);
            end

            op_imm, op_reg: begin
                ctrl.load_regfile = 1'b1;
                case (funct3_i)
                    3'b000: ctrl.alu_op = (!imm_form && alt) ? alu_sub : alu_add;
                    3'b010: begin   // slt / slti
                        ctrl.cmpop   = blt;
                        ctrl.cmp_src = imm_form ? cmp_i_imm : cmp_rs2;
                    end
                    3'b011: begin   // sltu / sltiu
                        ctrl.cmpop   = bltu;
                        ctrl.cmp_src = imm_form ? cmp_i_imm : cmp_rs2;
                    end
                    3'b101:  ctrl.alu_op = alt ? alu_sra : alu_srl;
                    default: ctrl.alu_op = alu_op_t'(funct3_i); // sll xor or and
                endcase
            end

            default: begin
                ctrl.illegal = 1'b1;    // csr, fence, system, junk
            end
        endcase
    end

    // illegal encodings never write anything
    always_comb begin
        ctrl_o = ctrl;
        if (ctrl.illegal) begin
            ctrl_o.load_regfile = 1'b0;
            ctrl_o.mem_read     = 1'b0;
            ctrl_o.mem_write    = 1'b0;
            ctrl_o.mem_byte_en  = 4'b0000;
        end
    end

endmodule : control_rom

`default_nettype wire

// File: id_stage/regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defines.svh"

module regfile
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  rv_word_t wr_data_i,
    input  reg_idx_t rd_a_idx_i,
    input  reg_idx_t rd_b_idx_i,
    output rv_word_t rd_a_o,
    output rv_word_t rd_b_o
);

    rv_word_t regs [`RV_NUM_REGS];
    logic     wr_live;          // write that actually lands

    assign wr_live = wr_en_i && (wr_idx_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // x0 reads zero, same-cycle write forwarded to the read
    assign rd_a_o = (rd_a_idx_i == '0) ? '0 :
                    (wr_live && (wr_idx_i == rd_a_idx_i)) ? wr_data_i : regs[rd_a_idx_i];
    assign rd_b_o = (rd_b_idx_i == '0) ? '0 :
                    (wr_live && (wr_idx_i == rd_b_idx_i)) ? wr_data_i : regs[rd_b_idx_i];

endmodule : regfile

`default_nettype wire

// File: id_stage/branch_cmp.sv
`timescale 1ns/10ps
`default_nettype none

module branch_cmp
    import rv32i_pkg::*;
(
    input  branch_funct3_t cmpop_i,
    input  rv_word_t       lhs_i,
    input  rv_word_t       rhs_i,
    output logic           br_en_o
);

    // shared by branches and the slt family
    always_comb begin
        case (cmpop_i)
            beq:     br_en_o = (lhs_i == rhs_i);
            bne:     br_en_o = (lhs_i != rhs_i);
            blt:     br_en_o = ($signed(lhs_i) < $signed(rhs_i));
            bge:     br_en_o = ($signed(lhs_i) >= $signed(rhs_i));
            bltu:    br_en_o = (lhs_i < rhs_i);
            bgeu:    br_en_o = (lhs_i >= rhs_i);
            default: br_en_o = 1'b0;    // unused funct3
        endcase
    end

endmodule : branch_cmp

`default_nettype wire

// File: id_stage/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  rv_word_t instr_i,
    input  rv_word_t pc_i,
    input  logic     valid_i,
    input  logic     bubble_i,      // from hazard unit
    input  logic     wb_load_i,
    input  reg_idx_t wb_rd_i,
    input  rv_word_t wb_data_i,
    output id_ex_t   pkt_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1, rs2, rd;
    rv_word_t   i_imm, s_imm, b_imm, u_imm, j_imm;
    rv_word_t   rs1_data, rs2_data;
    rv_word_t   cmp_rhs;
    ctrl_word_t ctrl;
    logic       br_en;
    logic       kill;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    // sign-extended immediates, all five formats every cycle
    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign j_imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    control_rom u_control_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl)
    );

    regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (wb_load_i),
        .wr_idx_i   (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .rd_a_idx_i (rs1),
        .rd_b_idx_i (rs2),
        .rd_a_o     (rs1_data),
        .rd_b_o     (rs2_data)
    );

    assign cmp_rhs = (ctrl.cmp_src == cmp_i_imm) ? i_imm : rs2_data;

    branch_cmp u_branch_cmp (
        .cmpop_i (ctrl.cmpop),
        .lhs_i   (rs1_data),
        .rhs_i   (cmp_rhs),
        .br_en_o (br_en)
    );

    // stall bubble, idle fetch or bad encoding
    assign kill = bubble_i || !valid_i || ctrl.illegal;

    always_comb begin
        pkt_o.valid    = !kill;
        pkt_o.ctrl     = ctrl;
        if (kill) begin
            pkt_o.ctrl.load_regfile = 1'b0;
            pkt_o.ctrl.mem_read     = 1'b0;
            pkt_o.ctrl.mem_write    = 1'b0;
            pkt_o.ctrl.mem_byte_en  = 4'b0000;
        end
        pkt_o.pc       = pc_i;
        pkt_o.instr    = instr_i;
        pkt_o.rs1_data = rs1_data;
        pkt_o.rs2_data = rs2_data;
        pkt_o.i_imm    = i_imm;
        pkt_o.s_imm    = s_imm;
        pkt_o.b_imm    = b_imm;
        pkt_o.u_imm    = u_imm;
        pkt_o.j_imm    = j_imm;
        pkt_o.rs1      = rs1;
        pkt_o.rs2      = rs2;
        pkt_o.rd       = rd;
        pkt_o.br_en    = br_en;
    end

endmodule : id_stage

`default_nettype wire

// File: rtl/hazard_detect.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_detect
    import rv32i_pkg::*;
(
    input  logic     id_valid_i,
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,
    input  opcode_t  id_opcode_i,
    input  id_ex_t   ex_pkt_i,      // current ID/EX contents
    output logic     stall_o        // doubles as bubble request
);

    logic reads_rs1;
    logic reads_rs2;
    logic ex_load;

    // which sources the instruction in ID really reads
    always_comb begin
        case (id_opcode_i)
            op_jalr, op_load, op_imm: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b0;
            end
            op_br, op_store, op_reg: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            default: begin  // lui auipc jal, illegal
                reads_rs1 = 1'b0;
                reads_rs2 = 1'b0;
            end
        endcase
    end

    // load in EX whose result is not ready for ID
    assign ex_load = ex_pkt_i.valid && ex_pkt_i.ctrl.mem_read && (ex_pkt_i.rd != '0);

    assign stall_o = id_valid_i && ex_load &&
                     ((reads_rs1 && (id_rs1_i == ex_pkt_i.rd)) ||
                      (reads_rs2 && (id_rs2_i == ex_pkt_i.rd)));

endmodule : hazard_detect

`default_nettype wire

// File: rtl/decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_top
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,

    // fetch side
    input  logic     if_valid_i,
    input  rv_word_t if_instr_i,
    input  rv_word_t if_pc_i,
    output logic     id_stall_o,

    // writeback port
    input  logic     wb_load_i,
    input  reg_idx_t wb_rd_i,
    input  rv_word_t wb_data_i,

    // to execute
    output id_ex_t   ex_pkt_o
);

    id_ex_t id_pkt;     // combinational decode result
    logic   stall;

    id_stage u_id_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .instr_i   (if_instr_i),
        .pc_i      (if_pc_i),
        .valid_i   (if_valid_i),
        .bubble_i  (stall),
        .wb_load_i (wb_load_i),
        .wb_rd_i   (wb_rd_i),
        .wb_data_i (wb_data_i),
        .pkt_o     (id_pkt)
    );

    // fetch valid, not pkt valid, which already folds in the stall
    hazard_detect u_hazard_detect (
        .id_valid_i  (if_valid_i),
        .id_rs1_i    (id_pkt.rs1),
        .id_rs2_i    (id_pkt.rs2),
        .id_opcode_i (id_pkt.ctrl.opcode),
        .ex_pkt_i    (ex_pkt_o),
        .stall_o     (stall)
    );

    assign id_stall_o = stall;  // fetch holds instr and pc

    // ID/EX register, loads every cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_pkt_o <= '0;
        end else begin
            ex_pkt_o <= id_pkt;   // bubble when stalled or idle
        end
    end

endmodule : decode_top

`default_nettype wire

// File: test/decode_chk.sv
`timescale 1ns/10ps
`default_nettype none

module decode_chk
    import rv32i_pkg::*;
(
    input logic   clk,
    input logic   reset_i,
    input logic   id_stall_o,
    input id_ex_t ex_pkt_o
);

    int fail_count = 0;     // assertion failures so far

    // ID/EX cleared by reset
    a_reset_clear: assert property (@(posedge clk) reset_i |=> (ex_pkt_o == '0))
        else begin
            fail_count++;
            $error("ID/EX not cleared after reset");
        end

    // bubbles never write or touch memory
    a_bubble_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !ex_pkt_o.valid |-> (!ex_pkt_o.ctrl.load_regfile && !ex_pkt_o.ctrl.mem_read &&
                             !ex_pkt_o.ctrl.mem_write && (ex_pkt_o.ctrl.mem_byte_en == 4'b0)))
        else begin
            fail_count++;
            $error("invalid packet carries enables");
        end

    // one bubble always clears a load-use hazard
    a_single_stall: assert property (@(posedge clk) disable iff (reset_i)
        id_stall_o |=> !id_stall_o)
        else begin
            fail_count++;
            $error("stall held for two cycles");
        end

endmodule : decode_chk

bind decode_top decode_chk u_chk (
    .clk        (clk),
    .reset_i    (reset_i),
    .id_stall_o (id_stall_o),
    .ex_pkt_o   (ex_pkt_o)
);

`default_nettype wire

// File: test/decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv32i_defines.svh"

module decode_tb
    import rv32i_pkg::*;
;

    localparam int N_RAND     = 200;
    localparam int MAX_CYCLES = 2 * N_RAND + 2 * 150 + 64 * 6 + 80 + 200;

    logic clk = 1'b0;
    logic reset_i = 1'b1;
    logic if_valid_i = 1'b0;
    rv_word_t if_instr_i = `RV_NOP_INSTR;
    rv_word_t if_pc_i = '0;
    logic wb_load_i = 1'b0;
    reg_idx_t wb_rd_i = '0;
    rv_word_t wb_data_i = '0;
    logic id_stall_o;
    id_ex_t ex_pkt_o;

    rv_word_t ref_regs [`RV_NUM_REGS];
    id_ex_t exp_pkt = '0;
    id_ex_t prev_pkt;
    logic exp_live = 1'b0;
    int seed = 2875;
    int errors = 0;
    int test_errs;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    string cur_test = "reset";

    always #4 clk = ~clk;

    decode_top u_dut (
        .clk (clk), .reset_i (reset_i),
        .if_valid_i (if_valid_i), .if_instr_i (if_instr_i), .if_pc_i (if_pc_i),
        .id_stall_o (id_stall_o),
        .wb_load_i (wb_load_i), .wb_rd_i (wb_rd_i), .wb_data_i (wb_data_i),
        .ex_pkt_o (ex_pkt_o)
    );

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, name, expected, actual);
        end
    endtask

    // register read as ID sees it, writeback of this cycle bypassed
    function automatic rv_word_t reg_read(reg_idx_t idx);
        if (idx == 0)
            return '0;
        if (wb_load_i && wb_rd_i == idx)
            return wb_data_i;
        return ref_regs[idx];
    endfunction

    function automatic logic load_use(rv_word_t instr, logic valid, id_ex_t prev);
        logic [6:0] op;
        logic use1;
        logic use2;
        op   = instr[6:0];
        use1 = op inside {op_jalr, op_load, op_imm, op_br, op_store, op_reg};
        use2 = op inside {op_br, op_store, op_reg};
        if (!valid || !prev.valid || !prev.ctrl.mem_read || prev.rd == 0)
            return 1'b0;
        return (use1 && instr[19:15] == prev.rd) || (use2 && instr[24:20] == prev.rd);
    endfunction

    function automatic id_ex_t decode_ref(rv_word_t instr, rv_word_t pc, logic valid,
                                          logic bubble);
        id_ex_t p;
        logic [2:0] f3;
        logic [3:0] lanes;
        rv_word_t rhs;
        f3    = instr[14:12];
        lanes = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        p = '0;
        p.pc = pc;
        p.instr = instr;
        p.rd  = instr[11:7];
        p.rs1 = instr[19:15];
        p.rs2 = instr[24:20];
        p.rs1_data = reg_read(p.rs1);
        p.rs2_data = reg_read(p.rs2);
        p.i_imm = $signed(instr) >>> 20;
        p.s_imm = $signed({instr[31:25], instr[11:7], 20'b0}) >>> 20;
        p.b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        p.u_imm = instr & 32'hffff_f000;
        p.j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        p.ctrl.opcode = opcode_t'(instr[6:0]);
        p.ctrl.alu_op = alu_add;
        p.ctrl.cmpop = beq;
        p.ctrl.cmp_src = cmp_rs2;
        case (instr[6:0])
            op_lui, op_auipc, op_jal, op_jalr: p.ctrl.load_regfile = 1'b1;
            op_br: begin
                p.ctrl.cmpop = branch_funct3_t'(f3);
                p.ctrl.illegal = (f3 == 3'b010) || (f3 == 3'b011);
            end
            op_load: begin
                {p.ctrl.load_regfile, p.ctrl.mem_read} = 2'b11;
                p.ctrl.mem_byte_en = lanes;
                p.ctrl.illegal = !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            end
            op_store: begin
                p.ctrl.mem_write = 1'b1;
                p.ctrl.mem_byte_en = lanes;
                p.ctrl.illegal = f3 > 3'b010;
            end
            op_imm, op_reg: begin
                p.ctrl.load_regfile = 1'b1;
                case (f3)
                    3'b000: p.ctrl.alu_op = (instr[5] && instr[30]) ? alu_sub : alu_add;
                    3'b001: p.ctrl.alu_op = alu_sll;
                    3'b010: p.ctrl.cmpop = blt;
                    3'b011: p.ctrl.cmpop = bltu;
                    3'b100: p.ctrl.alu_op = alu_xor;
                    3'b101: p.ctrl.alu_op = instr[30] ? alu_sra : alu_srl;
                    3'b110: p.ctrl.alu_op = alu_or;
                    default: p.ctrl.alu_op = alu_and;
                endcase
                if (!instr[5] && f3[2:1] == 2'b01)
                    p.ctrl.cmp_src = cmp_i_imm;  // slti, sltiu
            end
            default: p.ctrl.illegal = 1'b1;
        endcase
        rhs = (p.ctrl.cmp_src == cmp_i_imm) ? p.i_imm : p.rs2_data;
        case (p.ctrl.cmpop)
            beq:  p.br_en = p.rs1_data == rhs;
            bne:  p.br_en = p.rs1_data != rhs;
            blt:  p.br_en = $signed(p.rs1_data) < $signed(rhs);
            bge:  p.br_en = !($signed(p.rs1_data) < $signed(rhs));
            bltu: p.br_en = p.rs1_data < rhs;
            bgeu: p.br_en = !(p.rs1_data < rhs);
            default: p.br_en = 1'b0;
        endcase
        p.valid = valid && !bubble && !p.ctrl.illegal;
        if (!p.valid)
            {p.ctrl.load_regfile, p.ctrl.mem_read, p.ctrl.mem_write, p.ctrl.mem_byte_en} = '0;
        return p;
    endfunction

    // one cycle of stimulus on the falling edge, returns the expected stall
    task automatic drive(rv_word_t instr, rv_word_t pc, logic valid, logic wb_en,
                         reg_idx_t wb_rd, rv_word_t wb_data, output logic stall);
        @(negedge clk);
        prev_pkt = exp_pkt;
        {if_instr_i, if_pc_i, if_valid_i} = {instr, pc, valid};
        {wb_load_i, wb_rd_i, wb_data_i} = {wb_en, wb_rd, wb_data};
        stall = load_use(instr, valid, prev_pkt);
        exp_pkt = decode_ref(instr, pc, valid, stall);
        exp_live = 1'b1;
        #1 check_value("id_stall_o", stall, id_stall_o);
        if (wb_en && wb_rd != 0)
            ref_regs[wb_rd] = wb_data;
    endtask

    // fetch keeps presenting the instruction while stalled
    // stalls counts the cycles the DUT raised id_stall_o
    task automatic fetch(rv_word_t instr, logic wb_en, reg_idx_t wb_rd, rv_word_t wb_data,
                         output int stalls);
        logic st;
        drive(instr, 32'h100 + cycles * 4, 1'b1, wb_en, wb_rd, wb_data, st);
        stalls = int'(id_stall_o);
        while (st) begin
            drive(instr, if_pc_i, 1'b1, 1'b0, '0, '0, st);
            stalls += int'(id_stall_o);
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errs)
            tests_failed++;
        $display("test %s finished, %0d mismatches", cur_test, errors - test_errs);
    endtask

    // compares ID/EX one step after each rising edge
    always begin
        @(posedge clk);
        #1;
        if (exp_live) begin
            check_value("valid", exp_pkt.valid, ex_pkt_o.valid);
            check_value("ctrl", exp_pkt.ctrl, ex_pkt_o.ctrl);
            check_value("pc", exp_pkt.pc, ex_pkt_o.pc);
            check_value("instr", exp_pkt.instr, ex_pkt_o.instr);
            check_value("rs1_data", exp_pkt.rs1_data, ex_pkt_o.rs1_data);
            check_value("rs2_data", exp_pkt.rs2_data, ex_pkt_o.rs2_data);
            check_value("i_imm", exp_pkt.i_imm, ex_pkt_o.i_imm);
            check_value("s_imm", exp_pkt.s_imm, ex_pkt_o.s_imm);
            check_value("b_imm", exp_pkt.b_imm, ex_pkt_o.b_imm);
            check_value("u_imm", exp_pkt.u_imm, ex_pkt_o.u_imm);
            check_value("j_imm", exp_pkt.j_imm, ex_pkt_o.j_imm);
            check_value("regs", {exp_pkt.rs1, exp_pkt.rs2, exp_pkt.rd},
                        {ex_pkt_o.rs1, ex_pkt_o.rs2, ex_pkt_o.rd});
            check_value("br_en", exp_pkt.br_en, ex_pkt_o.br_en);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [6:0] ops [9];
        rv_word_t corners [8];
        logic [11:0] imms [5];
        rv_word_t r;
        logic st;
        int n;
        ops = '{op_lui, op_auipc, op_jal, op_jalr, op_br, op_load, op_store, op_imm, op_reg};
        corners = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff,
                    32'hffff_fffe, 32'h0000_0800, 32'hffff_f800};
        imms = '{12'hfff, 12'h800, 12'h7ff, 12'h001, 12'h000};
        for (int i = 0; i < `RV_NUM_REGS; i++)
            ref_regs[i] = '0;

        start_test("reset_idle");
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        check_value("ex_pkt_o after reset", 0, |ex_pkt_o);
        for (int i = 0; i < 6; i++)
            drive($random(seed), $random(seed), 1'b0, 1'b0, '0, '0, st);
        end_test();

        start_test("field_decode");
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            fetch({r[31:7], ops[r[3:0] % 9]}, r[5], reg_idx_t'($random(seed)), $random(seed), n);
        end
        end_test();

        start_test("control_word");
        foreach (ops[k])
            for (int f3 = 0; f3 < 8; f3++)
                for (int f7 = 0; f7 < 2; f7++)
                    fetch({1'b0, f7[0], 5'd0, 5'd4, 5'd2, f3[2:0], 5'd9, ops[k]}, 1'b0, '0, '0, n);
        fetch(32'h0000_0073, 1'b0, '0, '0, n);     // ecall
        fetch(32'h0000_000f, 1'b0, '0, '0, n);     // fence
        end_test();

        start_test("register_file");
        fetch(`RV_NOP_INSTR, 1'b1, 5'd5, 32'hcafe_f00d, n);
        fetch(`RV_NOP_INSTR, 1'b1, 5'd0, 32'hdead_beef, n);  // x0 stays zero
        fetch({7'd0, 5'd0, 5'd5, 3'b000, 5'd6, 7'b0110011}, 1'b0, '0, '0, n);
        fetch({7'd0, 5'd7, 5'd5, 3'b000, 5'd6, 7'b0110011}, 1'b1, 5'd7, 32'h1234_5678, n);
        @(posedge clk);
        #2 check_value("bypass", 32'h1234_5678, ex_pkt_o.rs2_data);
        end_test();

        start_test("branch_compare");
        foreach (corners[k])
            fetch(`RV_NOP_INSTR, 1'b1, reg_idx_t'(k + 1), corners[k], n);
        for (int a = 1; a <= 8; a++)
            for (int b = 1; b <= 8; b++)
                for (int c = 0; c < 8; c++)
                    if (c != 2 && c != 3)
                        fetch({7'd0, b[4:0], a[4:0], c[2:0], 5'd0, 7'b1100011}, 1'b0, '0, '0, n);
        for (int a = 1; a <= 8; a++)
            foreach (imms[k]) begin
                fetch({imms[k], a[4:0], 3'b010, 5'd10, 7'b0010011}, 1'b0, '0, '0, n);
                fetch({imms[k], a[4:0], 3'b011, 5'd10, 7'b0010011}, 1'b0, '0, '0, n);
            end
        end_test();

        start_test("load_use");
        fetch({12'h0, 5'd3, 3'b010, 5'd5, 7'b0000011}, 1'b0, '0, '0, n);   // lw x5
        fetch({7'd0, 5'd1, 5'd5, 3'b000, 5'd6, 7'b0110011}, 1'b0, '0, '0, n);
        check_value("dependent stall cycles", 1, n);
        @(posedge clk);
        #2 check_value("held instruction valid", 1, ex_pkt_o.valid);
        fetch({12'h0, 5'd3, 3'b010, 5'd5, 7'b0000011}, 1'b0, '0, '0, n);
        fetch({7'd0, 5'd2, 5'd1, 3'b000, 5'd7, 7'b0110011}, 1'b0, '0, '0, n);
        check_value("independent stall cycles", 0, n);
        drive(`RV_NOP_INSTR, '0, 1'b0, 1'b0, '0, '0, st);
        @(posedge clk);
        #2 exp_live = 1'b0;
        check_value("idle valid", 0, ex_pkt_o.valid);
        end_test();

        errors += u_dut.u_chk.fail_count;
        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : decode_tb

`default_nettype wire

// File: rv32i_decode.f
+incdir+common
common/rv32i_pkg.sv
id_stage/control_rom.sv
id_stage/regfile.sv
id_stage/branch_cmp.sv
id_stage/id_stage.sv
rtl/hazard_detect.sv
rtl/decode_top.sv
test/decode_chk.sv
test/decode_tb.sv
